//--- verilog/debug_bridge_pkg.sv
// Debug bridge shared definitions
`default_nettype none

package debug_bridge_pkg;

    // Register bus
    localparam int ADDR_W = 3;
    localparam int DATA_W = 32;

    // Character log
    localparam int CHAR_W    = 8;
    localparam int LOG_DEPTH = 16;
    localparam int LOG_PTR_W = $clog2(LOG_DEPTH);
    localparam int LOG_CNT_W = LOG_PTR_W + 1;  // Holds 0..LOG_DEPTH

    // Entropy feed
    localparam int NIBBLE_W         = 4;
    localparam int NIBBLES_PER_WORD = DATA_W / NIBBLE_W;  // 8 nibbles per word
    localparam int NIB_IDX_W        = $clog2(NIBBLES_PER_WORD);
    localparam int TRNG_DEPTH       = 4;
    localparam int TRNG_PTR_W       = $clog2(TRNG_DEPTH);
    localparam int TRNG_CNT_W       = TRNG_PTR_W + 1;

    // Register word addresses, also the bus opcode
    typedef enum logic [ADDR_W-1:0] {
        REG_LOG_DATA     = 3'd0,  // [8] char_valid, [7:0] char, read pops
        REG_LOG_STATUS   = 3'd1,  // [0] empty, [1] full
        REG_TRNG_DATA    = 3'd2,  // Write only, pushes one entropy word
        REG_TRNG_CTRL    = 3'd3,  // Rd [0] empty [1] full, wr [0] clear
        REG_TRNG_DIVISOR = 3'd4,
        REG_CYCLE_COUNT  = 3'd5
    } reg_addr_e;

endpackage

`default_nettype wire

//--- verilog/log_fifo.sv
// Character log FIFO, first word fall through
`default_nettype none

module log_fifo (
    input  wire                                  core_clk,
    input  wire                                  hwif_out,
    input  wire                                  log_wr,
    input  wire  [debug_bridge_pkg::CHAR_W-1:0]  log_char,
    input  wire                                  log_pop,
    output logic [debug_bridge_pkg::CHAR_W-1:0]  log_head,
    output logic                                 log_empty,
    output logic                                 log_full
);

    logic [debug_bridge_pkg::CHAR_W-1:0]    mem [debug_bridge_pkg::LOG_DEPTH];
    logic [debug_bridge_pkg::LOG_PTR_W-1:0] wr_ptr;
    logic [debug_bridge_pkg::LOG_PTR_W-1:0] rd_ptr;
    logic [debug_bridge_pkg::LOG_CNT_W-1:0] count;
    logic                                   push_ok;
    logic                                   pop_ok;

    assign log_empty = (count == '0);
    assign log_full  = (count == (debug_bridge_pkg::LOG_CNT_W)'(debug_bridge_pkg::LOG_DEPTH));

    // Full drops the push, empty ignores the pop
    assign push_ok = log_wr & ~log_full;
    assign pop_ok  = log_pop & ~log_empty;

    assign log_head = mem[rd_ptr];  // Head falls through

    // Storage
    always_ff @(posedge core_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= log_char;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle, or push and pop together
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/itrng_feed.sv
// Internal TRNG feed
// Entropy words out as throttled nibbles
`default_nettype none

module itrng_feed (
    input  wire                                   core_clk,
    input  wire                                   hwif_out,
    input  wire                                   trng_push,
    input  wire  [debug_bridge_pkg::DATA_W-1:0]   trng_word,
    input  wire                                   trng_clear,
    input  wire  [debug_bridge_pkg::DATA_W-1:0]   divisor,
    input  wire                                   etrng_req,
    output logic [debug_bridge_pkg::NIBBLE_W-1:0] itrng_data,
    output logic                                  itrng_valid,
    output logic                                  trng_empty,
    output logic                                  trng_full
);

    logic [debug_bridge_pkg::DATA_W-1:0]     mem [debug_bridge_pkg::TRNG_DEPTH];
    logic [debug_bridge_pkg::TRNG_PTR_W-1:0] wr_ptr;
    logic [debug_bridge_pkg::TRNG_PTR_W-1:0] rd_ptr;
    logic [debug_bridge_pkg::TRNG_CNT_W-1:0] count;
    logic [debug_bridge_pkg::NIB_IDX_W-1:0]  nib_idx;
    logic [debug_bridge_pkg::DATA_W-1:0]     throttle_cnt;
    logic                                    throttled_req;
    logic                                    push_ok;
    logic                                    take;
    logic                                    last_nib;
    logic                                    pop_word;

    assign trng_empty = (count == '0);
    assign trng_full  = (count == (debug_bridge_pkg::TRNG_CNT_W)'(debug_bridge_pkg::TRNG_DEPTH));

    assign push_ok  = trng_push & ~trng_full;
    assign take     = throttled_req & ~trng_empty;  // Request with nothing queued is lost
    assign last_nib = (nib_idx ==
                       (debug_bridge_pkg::NIB_IDX_W)'(debug_bridge_pkg::NIBBLES_PER_WORD - 1));
    assign pop_word = take & last_nib;  // Eighth nibble frees the word

    // Request throttle
    // Reload on zero, so accepted requests sit divisor+1 cycles apart
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            throttle_cnt  <= '0;
            throttled_req <= 1'b0;
        end else if (throttle_cnt == '0) begin
            throttle_cnt  <= divisor;
            throttled_req <= etrng_req;
        end else begin
            throttle_cnt  <= throttle_cnt - 1'b1;
            throttled_req <= 1'b0;
        end
    end

    // Word storage
    always_ff @(posedge core_clk) begin
        if (push_ok && !trng_clear) begin
            mem[wr_ptr] <= trng_word;
        end
    end

    // Queue control, clear beats everything else
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            nib_idx     <= '0;
            itrng_valid <= 1'b0;
        end else if (trng_clear) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            nib_idx     <= '0;
            itrng_valid <= 1'b0;
        end else begin
            itrng_valid <= take;
            if (take) begin
                nib_idx <= nib_idx + 1'b1;  // Wraps back to 0 after the last nibble
            end
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_word) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_word})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Lowest nibble goes first
    always_ff @(posedge core_clk) begin
        if (take) begin
            itrng_data <= mem[rd_ptr][nib_idx * debug_bridge_pkg::NIBBLE_W +:
                                      debug_bridge_pkg::NIBBLE_W];
        end
    end

endmodule

`default_nettype wire

//--- verilog/bridge_regs.sv
// Bridge register block
// Strobe decode, read mux and cycle counter
`default_nettype none

module bridge_regs (
    input  wire                                  core_clk,
    input  wire                                  hwif_out,
    // Register strobes
    input  wire                                  wr_en,
    input  wire  [debug_bridge_pkg::ADDR_W-1:0]  wr_addr,
    input  wire  [debug_bridge_pkg::DATA_W-1:0]  wr_data,
    input  wire                                  rd_en,
    input  wire  [debug_bridge_pkg::ADDR_W-1:0]  rd_addr,
    output logic                                 rd_valid,
    output logic [debug_bridge_pkg::DATA_W-1:0]  rd_data,
    // Log FIFO side
    input  wire  [debug_bridge_pkg::CHAR_W-1:0]  log_head,
    input  wire                                  log_empty,
    input  wire                                  log_full,
    output logic                                 log_pop,
    // Entropy side
    input  wire                                  trng_empty,
    input  wire                                  trng_full,
    output logic                                 trng_push,
    output logic [debug_bridge_pkg::DATA_W-1:0]  trng_word,
    output logic                                 trng_clear,
    output logic [debug_bridge_pkg::DATA_W-1:0]  divisor
);

    debug_bridge_pkg::reg_addr_e         wr_sel;
    debug_bridge_pkg::reg_addr_e         rd_sel;
    logic                                char_valid_q;
    logic                                char_valid;
    logic [debug_bridge_pkg::DATA_W-1:0] cycle_count;
    logic [debug_bridge_pkg::DATA_W-1:0] rd_mux;

    assign wr_sel = debug_bridge_pkg::reg_addr_e'(wr_addr);
    assign rd_sel = debug_bridge_pkg::reg_addr_e'(rd_addr);

    // Write side, pulses land on the same edge as the strobe
    assign trng_push  = wr_en && (wr_sel == debug_bridge_pkg::REG_TRNG_DATA);
    assign trng_word  = wr_data;
    assign trng_clear = wr_en && (wr_sel == debug_bridge_pkg::REG_TRNG_CTRL) && wr_data[0];

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            divisor <= '0;
        end else if (wr_en && (wr_sel == debug_bridge_pkg::REG_TRNG_DIVISOR)) begin
            divisor <= wr_data;
        end
    end

    // Char is only valid if it was already there a cycle before the read
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            char_valid_q <= 1'b0;
        end else begin
            char_valid_q <= ~log_empty;
        end
    end

    assign char_valid = char_valid_q & ~log_empty;
    assign log_pop    = rd_en && (rd_sel == debug_bridge_pkg::REG_LOG_DATA) && char_valid;

    // Free-running cycle counter
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    // Read mux
    always_comb begin
        rd_mux = '0;
        case (rd_sel)
            debug_bridge_pkg::REG_LOG_DATA: begin
                rd_mux[debug_bridge_pkg::CHAR_W-1:0] = log_head;
                rd_mux[debug_bridge_pkg::CHAR_W]     = char_valid;
            end
            debug_bridge_pkg::REG_LOG_STATUS: begin
                rd_mux[0] = log_empty;
                rd_mux[1] = log_full;
            end
            debug_bridge_pkg::REG_TRNG_CTRL: begin
                rd_mux[0] = trng_empty;
                rd_mux[1] = trng_full;
            end
            debug_bridge_pkg::REG_TRNG_DIVISOR: rd_mux = divisor;
            debug_bridge_pkg::REG_CYCLE_COUNT:  rd_mux = cycle_count;
            default:                            rd_mux = '0;  // TRNG_DATA is write only
        endcase
    end

    // One-cycle read return
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    always_ff @(posedge core_clk) begin
        if (rd_en) begin
            rd_data <= rd_mux;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fpga_debug_bridge.sv
// FPGA debug and entropy bridge top
`default_nettype none

module fpga_debug_bridge (
    input  wire                                   core_clk,
    input  wire                                   hwif_out,
    // Firmware character log
    input  wire                                   log_wr,
    input  wire  [debug_bridge_pkg::CHAR_W-1:0]   log_char,
    // Host register port
    input  wire                                   wr_en,
    input  wire  [debug_bridge_pkg::ADDR_W-1:0]   wr_addr,
    input  wire  [debug_bridge_pkg::DATA_W-1:0]   wr_data,
    input  wire                                   rd_en,
    input  wire  [debug_bridge_pkg::ADDR_W-1:0]   rd_addr,
    output logic                                  rd_valid,
    output logic [debug_bridge_pkg::DATA_W-1:0]   rd_data,
    // Entropy
    input  wire                                   etrng_req,
    output logic [debug_bridge_pkg::NIBBLE_W-1:0] itrng_data,
    output logic                                  itrng_valid
);

    logic [debug_bridge_pkg::CHAR_W-1:0] log_head;
    logic                                log_empty;
    logic                                log_full;
    logic                                log_pop;
    logic                                trng_empty;
    logic                                trng_full;
    logic                                trng_push;
    logic [debug_bridge_pkg::DATA_W-1:0] trng_word;
    logic                                trng_clear;
    logic [debug_bridge_pkg::DATA_W-1:0] divisor;

    log_fifo u_log_fifo (
        .core_clk  (core_clk),
        .hwif_out  (hwif_out),
        .log_wr    (log_wr),
        .log_char  (log_char),
        .log_pop   (log_pop),
        .log_head  (log_head),
        .log_empty (log_empty),
        .log_full  (log_full)
    );

    itrng_feed u_itrng_feed (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .trng_push   (trng_push),
        .trng_word   (trng_word),
        .trng_clear  (trng_clear),
        .divisor     (divisor),
        .etrng_req   (etrng_req),
        .itrng_data  (itrng_data),
        .itrng_valid (itrng_valid),
        .trng_empty  (trng_empty),
        .trng_full   (trng_full)
    );

    bridge_regs u_bridge_regs (
        .core_clk   (core_clk),
        .hwif_out   (hwif_out),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .log_head   (log_head),
        .log_empty  (log_empty),
        .log_full   (log_full),
        .log_pop    (log_pop),
        .trng_empty (trng_empty),
        .trng_full  (trng_full),
        .trng_push  (trng_push),
        .trng_word  (trng_word),
        .trng_clear (trng_clear),
        .divisor    (divisor)
    );

endmodule

`default_nettype wire

//--- tb/bridge_checker.sv
// Bridge protocol assertions
`default_nettype none

module bridge_checker (
    input wire core_clk,
    input wire hwif_out,
    input wire rd_en,
    input wire rd_valid,
    input wire log_pop,
    input wire log_empty,
    input wire itrng_valid,
    input wire trng_empty
);

    int unsigned fail_count = 0;

    // Read return is exactly one cycle behind the strobe
    rd_valid_follows_rd_en: assert property (@(posedge core_clk) disable iff (!hwif_out)
        rd_valid == $past(rd_en))
    else begin
        $error("rd_valid did not follow rd_en by one cycle");
        fail_count++;
    end

    no_pop_when_empty: assert property (@(posedge core_clk) disable iff (!hwif_out)
        !(log_pop && log_empty))
    else begin
        $error("log_pop asserted while the log FIFO was empty");
        fail_count++;
    end

    // itrng_valid is registered, so it looks at the queue one cycle back
    no_nibble_from_empty: assert property (@(posedge core_clk) disable iff (!hwif_out)
        itrng_valid |-> !$past(trng_empty))
    else begin
        $error("itrng_valid raised with no entropy word queued");
        fail_count++;
    end

endmodule

bind fpga_debug_bridge bridge_checker u_checker (
    .core_clk    (core_clk),
    .hwif_out    (hwif_out),
    .rd_en       (rd_en),
    .rd_valid    (rd_valid),
    .log_pop     (log_pop),
    .log_empty   (log_empty),
    .itrng_valid (itrng_valid),
    .trng_empty  (trng_empty)
);

`default_nettype wire

//--- tb/tb_fpga_debug_bridge.sv
// Debug bridge testbench
`default_nettype none

module tb_fpga_debug_bridge;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 5;
    localparam int RESET_CYCLES = 3;
    localparam int MAX_OPS      = 128;
    localparam int ENT_WINDOW   = 40;  // Longest etrng_req hold per window
    localparam int ENT_TAIL     = 4;
    localparam int RD_TIMEOUT   = 8;
    localparam int OP_LOG       = 0;
    localparam int OP_WR        = 1;
    localparam int OP_RD        = 2;
    localparam int OP_ENT       = 3;  // data is nibble count, exp is minimum gap
    localparam int OP_CYC       = 4;  // data is strobe distance

    logic                                  core_clk;
    logic                                  hwif_out;
    logic                                  log_wr;
    logic [debug_bridge_pkg::CHAR_W-1:0]   log_char;
    logic                                  wr_en;
    logic [debug_bridge_pkg::ADDR_W-1:0]   wr_addr;
    logic [debug_bridge_pkg::DATA_W-1:0]   wr_data;
    logic                                  rd_en;
    logic [debug_bridge_pkg::ADDR_W-1:0]   rd_addr;
    logic                                  rd_valid;
    logic [debug_bridge_pkg::DATA_W-1:0]   rd_data;
    logic                                  etrng_req;
    logic [debug_bridge_pkg::NIBBLE_W-1:0] itrng_data;
    logic                                  itrng_valid;

    // Stimulus table with one column per field
    int          op_kind [MAX_OPS];
    logic [2:0]  op_addr [MAX_OPS];
    logic [31:0] op_data [MAX_OPS];
    logic [31:0] op_exp  [MAX_OPS];
    logic [31:0] op_mask [MAX_OPS];
    int          n_ops = 0;
    logic        table_ready = 1'b0;

    logic [7:0]  log_model [$];  // Characters the FIFO should hold
    logic [3:0]  pend_nib [$];   // Nibbles queued but not yet requested
    logic [3:0]  exp_nib [$];    // Nibbles each window should return in order
    int          value_errors = 0;
    int          proto_errors = 0;
    int unsigned assert_errors;

    fpga_debug_bridge DUT (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .log_wr      (log_wr),
        .log_char    (log_char),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .etrng_req   (etrng_req),
        .itrng_data  (itrng_data),
        .itrng_valid (itrng_valid)
    );

    initial begin
        core_clk = 1'b0;
        forever #(CLK_PERIOD / 2) core_clk = ~core_clk;
    end

    task automatic add_entry(input int kind, input logic [2:0] addr, input logic [31:0] data,
                             input logic [31:0] exp, input logic [31:0] mask);
        op_kind[n_ops] = kind;
        op_addr[n_ops] = addr;
        op_data[n_ops] = data;
        op_exp[n_ops]  = exp;
        op_mask[n_ops] = mask;
        n_ops++;
    endtask

    task automatic log_char_entry();
        logic [7:0] ch;
        ch = 8'($urandom());
        if (log_model.size() < debug_bridge_pkg::LOG_DEPTH) begin
            log_model.push_back(ch);  // Pushes into a full FIFO are lost
        end
        add_entry(OP_LOG, 3'd0, {24'd0, ch}, 0, 0);
    endtask

    task automatic log_read_entry();
        add_entry(OP_RD, debug_bridge_pkg::REG_LOG_DATA, 0,
                  32'h100 | {24'd0, log_model.pop_front()}, 32'h1FF);
    endtask

    task automatic trng_word_entry();
        logic [31:0] w;
        w = $urandom();
        for (int j = 0; j < debug_bridge_pkg::NIBBLES_PER_WORD; j++) begin
            pend_nib.push_back(4'(w >> (debug_bridge_pkg::NIBBLE_W * j)));  // Low first
        end
        add_entry(OP_WR, debug_bridge_pkg::REG_TRNG_DATA, w, 0, 0);
    endtask

    task automatic nibble_entry(input int n, input int min_gap);
        repeat (n) exp_nib.push_back(pend_nib.pop_front());
        add_entry(OP_ENT, 3'd0, 32'(n), 32'(min_gap), 0);
    endtask

    task automatic build_table();
        add_entry(OP_RD, debug_bridge_pkg::REG_LOG_STATUS, 0, 32'h1, 32'h3);
        add_entry(OP_RD, debug_bridge_pkg::REG_TRNG_CTRL, 0, 32'h1, 32'h3);
        add_entry(OP_RD, debug_bridge_pkg::REG_CYCLE_COUNT, 0, 32'h0, 32'hFFFF_FFC0);
        repeat (10) log_char_entry();
        repeat (10) log_read_entry();
        add_entry(OP_RD, debug_bridge_pkg::REG_LOG_DATA, 0, 32'h0, 32'h100);
        add_entry(OP_RD, debug_bridge_pkg::REG_LOG_STATUS, 0, 32'h1, 32'h3);
        // Overflow by two
        repeat (debug_bridge_pkg::LOG_DEPTH + 2) log_char_entry();
        add_entry(OP_RD, debug_bridge_pkg::REG_LOG_STATUS, 0, 32'h2, 32'h3);
        repeat (debug_bridge_pkg::LOG_DEPTH) log_read_entry();
        add_entry(OP_RD, debug_bridge_pkg::REG_LOG_DATA, 0, 32'h0, 32'h100);
        // Two words at full entropy rate
        add_entry(OP_WR, debug_bridge_pkg::REG_TRNG_DIVISOR, 0, 0, 0);
        repeat (2) trng_word_entry();
        nibble_entry(16, 1);
        add_entry(OP_RD, debug_bridge_pkg::REG_TRNG_CTRL, 0, 32'h1, 32'h1);
        // Throttled and then cleared partway through the word
        add_entry(OP_WR, debug_bridge_pkg::REG_TRNG_DIVISOR, 3, 0, 0);
        trng_word_entry();
        nibble_entry(3, 4);
        add_entry(OP_WR, debug_bridge_pkg::REG_TRNG_CTRL, 1, 0, 0);
        pend_nib.delete();
        nibble_entry(0, 4);
        add_entry(OP_RD, debug_bridge_pkg::REG_TRNG_CTRL, 0, 32'h1, 32'h1);
        add_entry(OP_CYC, debug_bridge_pkg::REG_CYCLE_COUNT, 7, 0, 0);
        add_entry(OP_CYC, debug_bridge_pkg::REG_CYCLE_COUNT, 13, 0, 0);
    endtask

    task automatic next_cycle();
        @(posedge core_clk);
        #DRIVE_DLY;
    endtask

    task automatic reg_read(input logic [2:0] addr, output logic [31:0] data);
        int waited;
        waited   = 0;
        rd_en    = 1'b1;
        rd_addr  = addr;
        next_cycle();
        rd_en    = 1'b0;
        while (!rd_valid && waited < RD_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        assert (rd_valid) else begin
            $display("Read of address %0d never returned rd_valid", addr);
            proto_errors++;
        end
        data = rd_data;
    endtask

    task automatic entropy_window(input int n, input int min_gap);
        int         got;
        int         cyc;
        int         last;
        int         tail;
        logic [3:0] want;
        got       = 0;
        cyc       = 0;
        last      = -1;
        tail      = 0;
        etrng_req = 1'b1;
        while (tail < ENT_TAIL) begin
            next_cycle();
            cyc++;
            if (itrng_valid) begin
                got++;
                if (got <= n) begin
                    want = exp_nib.pop_front();
                    assert (itrng_data == want) else begin
                        $display("FAIL @%0t: nibble %0d is 0x%0h, expected 0x%0h",
                                 $time, got, itrng_data, want);
                        value_errors++;
                    end
                end
                assert (last < 0 || cyc - last >= min_gap) else begin
                    $display("FAIL @%0t: nibbles %0d cycles apart, minimum %0d",
                             $time, cyc - last, min_gap);
                    value_errors++;
                end
                last = cyc;
            end
            if (!etrng_req) begin
                tail++;  // Catch anything still in flight
            end else if ((n > 0 && got >= n) || cyc >= ENT_WINDOW) begin
                etrng_req = 1'b0;
            end
        end
        assert (got == n) else begin
            $display("FAIL @%0t: %0d nibbles seen, expected %0d", $time, got, n);
            value_errors++;
        end
    endtask

    task automatic apply_entry(input int i);
        logic [31:0] val;
        logic [31:0] first;
        case (op_kind[i])
            OP_LOG: begin
                log_wr   = 1'b1;
                log_char = op_data[i][7:0];
                next_cycle();
                log_wr   = 1'b0;
            end
            OP_WR: begin
                wr_en   = 1'b1;
                wr_addr = op_addr[i];
                wr_data = op_data[i];
                next_cycle();
                wr_en   = 1'b0;
            end
            OP_RD: begin
                reg_read(op_addr[i], val);
                assert ((val & op_mask[i]) == op_exp[i]) else begin
                    $display("FAIL @%0t: read of address %0d gave 0x%08h, expected 0x%08h",
                             $time, op_addr[i], val & op_mask[i], op_exp[i]);
                    value_errors++;
                end
            end
            OP_ENT: entropy_window(int'(op_data[i]), int'(op_exp[i]));
            OP_CYC: begin
                reg_read(op_addr[i], first);
                repeat (op_data[i] - 1) next_cycle();  // Next strobe op_data cycles later
                reg_read(op_addr[i], val);
                assert (val - first == op_data[i]) else begin
                    $display("FAIL @%0t: cycle count moved by %0d over %0d cycles",
                             $time, val - first, op_data[i]);
                    value_errors++;
                end
            end
            default: begin
                $display("Table entry %0d has an unknown operation", i);
                proto_errors++;
            end
        endcase
    endtask

    initial begin : watchdog
        wait (table_ready);
        #(CLK_PERIOD * (RESET_CYCLES + n_ops * 64));
        $display("Watchdog expired before the %0d table entries finished", n_ops);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        hwif_out  = 1'b0;
        log_wr    = 1'b0;
        log_char  = '0;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        rd_en     = 1'b0;
        rd_addr   = '0;
        etrng_req = 1'b0;
        void'($urandom(32'h6550));
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge core_clk);
        #DRIVE_DLY;
        hwif_out = 1'b1;
        for (int i = 0; i < n_ops; i++) begin
            apply_entry(i);
        end
        assert_errors = DUT.u_checker.fail_count;
        $display("Errors: value %0d, protocol %0d, assertion %0d",
                 value_errors, proto_errors, assert_errors);
        if (value_errors == 0 && proto_errors == 0 && assert_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
verilog/debug_bridge_pkg.sv
verilog/log_fifo.sv
verilog/itrng_feed.sv
verilog/bridge_regs.sv
verilog/fpga_debug_bridge.sv
tb/bridge_checker.sv
tb/tb_fpga_debug_bridge.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --assert -j 0
TOP      := tb_fpga_debug_bridge
FILELIST := compile.f
OBJ_DIR  := obj_dir
RUN_ARGS := +verilator+error+limit+100
PASS_MSG := >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
